/* hw/matrix_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// matrix_pkg: default panel geometry, opcodes and address width helpers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package matrix_pkg;

    // default geometry, overridden through the top level parameters
    parameter int unsigned BYTES_PER_PIXEL = 3;
    parameter int unsigned PIXEL_WIDTH = 4;
    parameter int unsigned PIXEL_HEIGHT = 2;

    // command opcodes
    parameter logic [7:0] OP_LOAD_FRAME = 8'h01;
    parameter logic [7:0] OP_FILL_FRAME = 8'h02;

    // width of an index over n entries, never below one bit
    function automatic int unsigned index_bits(input int unsigned n);
        if (n > 1) begin
            return $clog2(n);
        end
        return 1;
    endfunction

    function automatic int unsigned num_row_address_bits(input int unsigned height);
        return index_bits(height);
    endfunction

    function automatic int unsigned num_column_address_bits(input int unsigned width);
        return index_bits(width);
    endfunction

    function automatic int unsigned num_pixelcolorselect_bits(
        input int unsigned bytes_per_pixel
    );
        return index_bits(bytes_per_pixel);
    endfunction

endpackage

`default_nettype wire

/* hw/cmd_dispatch.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cmd_dispatch: opcode decoder, routes payload bytes to the frame writers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cmd_dispatch #(
    parameter int unsigned BYTES_PER_PIXEL = matrix_pkg::BYTES_PER_PIXEL
) (
    input wire clk,
    input wire reset,
    input wire [7:0] data_in,
    input wire data_valid,
    input wire loader_done,
    input wire fill_done,

    output logic load_enable,
    output logic fill_enable,
    output logic busy,
    output logic cmd_error
);
    localparam int unsigned CB = matrix_pkg::num_pixelcolorselect_bits(BYTES_PER_PIXEL);
    localparam logic [CB-1:0] COLOUR_LAST = CB'(BYTES_PER_PIXEL - 1);

    typedef enum logic [1:0] {
        STATE_IDLE,
        STATE_LOAD,
        STATE_FILL
    } dispatch_state_t;

    dispatch_state_t state;
    logic [CB-1:0] colour_count;    // colour bytes taken so far

    // no byte goes to the loader in its done cycle, it has already re-primed
    assign load_enable = (state == STATE_LOAD) && data_valid && !loader_done;
    assign fill_enable = (state == STATE_FILL) && data_valid && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= STATE_IDLE;
            colour_count <= '0;
            busy <= 1'b0;
            cmd_error <= 1'b0;
        end else begin
            cmd_error <= 1'b0;
            case (state)
                STATE_IDLE: begin
                    if (data_valid) begin
                        if (data_in == matrix_pkg::OP_LOAD_FRAME) begin
                            state <= STATE_LOAD;
                        end else if (data_in == matrix_pkg::OP_FILL_FRAME) begin
                            state <= STATE_FILL;
                            colour_count <= '0;
                        end else begin
                            cmd_error <= 1'b1;  // unknown opcode, byte dropped
                        end
                    end
                end
                STATE_LOAD: begin
                    if (loader_done) begin
                        state <= STATE_IDLE;
                    end
                end
                STATE_FILL: begin
                    if (fill_enable) begin
                        colour_count <= colour_count + 1'b1;
                        if (colour_count == COLOUR_LAST) begin
                            busy <= 1'b1;   // sweep starts next cycle
                        end
                    end
                    if (fill_done) begin
                        busy <= 1'b0;
                        state <= STATE_IDLE;
                    end
                end
                default: state <= STATE_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/frame_loader.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame_loader: writes a frame of payload bytes, top address first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module frame_loader #(
    parameter int unsigned BYTES_PER_PIXEL = matrix_pkg::BYTES_PER_PIXEL,
    parameter int unsigned PIXEL_HEIGHT = matrix_pkg::PIXEL_HEIGHT,
    parameter int unsigned PIXEL_WIDTH = matrix_pkg::PIXEL_WIDTH
) (
    input wire clk,
    input wire reset,
    input wire enable,
    input wire [7:0] data_in,

    output logic [matrix_pkg::num_row_address_bits(PIXEL_HEIGHT)-1:0] row,
    output logic [matrix_pkg::num_column_address_bits(PIXEL_WIDTH)-1:0] column,
    output logic [matrix_pkg::num_pixelcolorselect_bits(BYTES_PER_PIXEL)-1:0] pixel,
    output logic [7:0] data_out,
    output logic ram_write_enable,
    output logic ram_access_start,
    output logic done
);
    localparam int unsigned RB = matrix_pkg::num_row_address_bits(PIXEL_HEIGHT);
    localparam int unsigned CB = matrix_pkg::num_column_address_bits(PIXEL_WIDTH);
    localparam int unsigned PB = matrix_pkg::num_pixelcolorselect_bits(BYTES_PER_PIXEL);
    localparam logic [RB-1:0] ROW_TOP = RB'(PIXEL_HEIGHT - 1);
    localparam logic [CB-1:0] COL_TOP = CB'(PIXEL_WIDTH - 1);
    localparam logic [PB-1:0] PIX_TOP = PB'(BYTES_PER_PIXEL - 1);
    localparam bit SINGLE_BYTE = (PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL) == 1;

    typedef enum logic {
        STATE_PRIME,
        STATE_RUN
    } loader_state_t;

    loader_state_t state;
    logic [RB-1:0] next_row;
    logic [CB-1:0] next_column;
    logic [PB-1:0] next_pixel;
    logic next_is_zero;

    // colour byte first, then column, then row
    always_comb begin
        next_row = row;
        next_column = column;
        next_pixel = pixel;
        if (pixel != '0) begin
            next_pixel = pixel - 1'b1;
        end else begin
            next_pixel = PIX_TOP;
            if (column != '0) begin
                next_column = column - 1'b1;
            end else begin
                next_column = COL_TOP;
                next_row = row - 1'b1;
            end
        end
        next_is_zero = (next_row == '0) && (next_column == '0) && (next_pixel == '0);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= STATE_PRIME;
            row <= '0;
            column <= '0;
            pixel <= '0;
            data_out <= 8'd0;
            ram_write_enable <= 1'b0;
            ram_access_start <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (done) begin
                ram_write_enable <= 1'b0;   // last byte went out the cycle before
            end
            if (enable) begin
                data_out <= data_in;
                ram_access_start <= !ram_access_start;
                if (state == STATE_PRIME) begin
                    row <= ROW_TOP;
                    column <= COL_TOP;
                    pixel <= PIX_TOP;
                    ram_write_enable <= 1'b1;
                    if (SINGLE_BYTE) begin
                        done <= 1'b1;
                    end else begin
                        state <= STATE_RUN;
                    end
                end else begin
                    row <= next_row;
                    column <= next_column;
                    pixel <= next_pixel;
                    if (next_is_zero) begin
                        done <= 1'b1;   // byte at address zero closes the frame
                        state <= STATE_PRIME;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/frame_fill.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame_fill: takes one colour and writes it to every pixel of the frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module frame_fill #(
    parameter int unsigned BYTES_PER_PIXEL = matrix_pkg::BYTES_PER_PIXEL,
    parameter int unsigned PIXEL_HEIGHT = matrix_pkg::PIXEL_HEIGHT,
    parameter int unsigned PIXEL_WIDTH = matrix_pkg::PIXEL_WIDTH
) (
    input wire clk,
    input wire reset,
    input wire enable,
    input wire [7:0] data_in,

    output logic [matrix_pkg::num_row_address_bits(PIXEL_HEIGHT)-1:0] fill_row,
    output logic [matrix_pkg::num_column_address_bits(PIXEL_WIDTH)-1:0] fill_column,
    output logic [matrix_pkg::num_pixelcolorselect_bits(BYTES_PER_PIXEL)-1:0] fill_pixel,
    output logic [7:0] fill_data,
    output logic fill_write,
    output logic done
);
    localparam int unsigned RB = matrix_pkg::num_row_address_bits(PIXEL_HEIGHT);
    localparam int unsigned CB = matrix_pkg::num_column_address_bits(PIXEL_WIDTH);
    localparam int unsigned PB = matrix_pkg::num_pixelcolorselect_bits(BYTES_PER_PIXEL);
    localparam logic [RB-1:0] ROW_TOP = RB'(PIXEL_HEIGHT - 1);
    localparam logic [CB-1:0] COL_TOP = CB'(PIXEL_WIDTH - 1);
    localparam logic [PB-1:0] PIX_TOP = PB'(BYTES_PER_PIXEL - 1);

    logic [7:0] colour [BYTES_PER_PIXEL];
    logic [PB-1:0] colour_count;
    logic at_zero;

    // first colour byte belongs to the highest select, like a loaded frame
    assign fill_data = colour[int'(PIX_TOP) - int'(fill_pixel)];
    assign at_zero = (fill_row == '0) && (fill_column == '0) && (fill_pixel == '0);

    always_ff @(posedge clk) begin
        if (enable && !fill_write) begin
            colour[colour_count] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            colour_count <= '0;
            fill_row <= '0;
            fill_column <= '0;
            fill_pixel <= '0;
            fill_write <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!fill_write) begin
                if (enable) begin
                    colour_count <= colour_count + 1'b1;
                    if (colour_count == PIX_TOP) begin
                        colour_count <= '0;
                        fill_row <= ROW_TOP;
                        fill_column <= COL_TOP;
                        fill_pixel <= PIX_TOP;
                        fill_write <= 1'b1;
                    end
                end
            end else if (at_zero) begin
                fill_write <= 1'b0;
                done <= 1'b1;
            end else if (fill_pixel != '0) begin
                fill_pixel <= fill_pixel - 1'b1;
            end else begin
                fill_pixel <= PIX_TOP;
                if (fill_column != '0) begin
                    fill_column <= fill_column - 1'b1;
                end else begin
                    fill_column <= COL_TOP;
                    fill_row <= fill_row - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/frame_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame_buffer: pixel byte memory, loader and fill write ports, one read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module frame_buffer #(
    parameter int unsigned BYTES_PER_PIXEL = matrix_pkg::BYTES_PER_PIXEL,
    parameter int unsigned PIXEL_HEIGHT = matrix_pkg::PIXEL_HEIGHT,
    parameter int unsigned PIXEL_WIDTH = matrix_pkg::PIXEL_WIDTH
) (
    input wire clk,
    input wire reset,

    // loader port, toggle strobed
    input wire [matrix_pkg::num_row_address_bits(PIXEL_HEIGHT)-1:0] row,
    input wire [matrix_pkg::num_column_address_bits(PIXEL_WIDTH)-1:0] column,
    input wire [matrix_pkg::num_pixelcolorselect_bits(BYTES_PER_PIXEL)-1:0] pixel,
    input wire [7:0] data_in,
    input wire ram_write_enable,
    input wire ram_access_start,

    // fill port, plain write pulse
    input wire [matrix_pkg::num_row_address_bits(PIXEL_HEIGHT)-1:0] fill_row,
    input wire [matrix_pkg::num_column_address_bits(PIXEL_WIDTH)-1:0] fill_column,
    input wire [matrix_pkg::num_pixelcolorselect_bits(BYTES_PER_PIXEL)-1:0] fill_pixel,
    input wire [7:0] fill_data,
    input wire fill_write,

    input wire [matrix_pkg::num_row_address_bits(PIXEL_HEIGHT)-1:0] rd_row,
    input wire [matrix_pkg::num_column_address_bits(PIXEL_WIDTH)-1:0] rd_column,
    input wire [matrix_pkg::num_pixelcolorselect_bits(BYTES_PER_PIXEL)-1:0] rd_pixel,
    output logic [7:0] rd_data
);
    localparam int unsigned DEPTH = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;

    logic [7:0] mem [DEPTH];
    logic access_q;     // last seen loader toggle
    int unsigned load_index;
    int unsigned fill_index;
    int unsigned rd_index;

    // linear order is row, then column, then colour byte
    assign load_index = (row * PIXEL_WIDTH + column) * BYTES_PER_PIXEL + pixel;
    assign fill_index = (fill_row * PIXEL_WIDTH + fill_column) * BYTES_PER_PIXEL + fill_pixel;
    assign rd_index = (rd_row * PIXEL_WIDTH + rd_column) * BYTES_PER_PIXEL + rd_pixel;

    always_ff @(posedge clk) begin
        if (reset) begin
            access_q <= 1'b0;
        end else begin
            access_q <= ram_access_start;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_write) begin
            mem[fill_index] <= fill_data;
        end else if (ram_write_enable && (ram_access_start != access_q)) begin
            mem[load_index] <= data_in;
        end
        rd_data <= mem[rd_index];
    end

endmodule

`default_nettype wire

/* hw/matrix_cmd_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// matrix_cmd_top: command front end of the LED matrix driver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module matrix_cmd_top #(
    parameter int unsigned BYTES_PER_PIXEL = matrix_pkg::BYTES_PER_PIXEL,
    parameter int unsigned PIXEL_HEIGHT = matrix_pkg::PIXEL_HEIGHT,
    parameter int unsigned PIXEL_WIDTH = matrix_pkg::PIXEL_WIDTH
) (
    input wire clk,
    input wire reset,
    input wire [7:0] data_in,
    input wire data_valid,
    input wire [matrix_pkg::num_row_address_bits(PIXEL_HEIGHT)-1:0] rd_row,
    input wire [matrix_pkg::num_column_address_bits(PIXEL_WIDTH)-1:0] rd_column,
    input wire [matrix_pkg::num_pixelcolorselect_bits(BYTES_PER_PIXEL)-1:0] rd_pixel,

    output logic [7:0] rd_data,
    output logic busy,
    output logic done,
    output logic cmd_error
);
    localparam int unsigned RB = matrix_pkg::num_row_address_bits(PIXEL_HEIGHT);
    localparam int unsigned CB = matrix_pkg::num_column_address_bits(PIXEL_WIDTH);
    localparam int unsigned PB = matrix_pkg::num_pixelcolorselect_bits(BYTES_PER_PIXEL);

    logic load_enable;
    logic fill_enable;
    logic loader_done;
    logic fill_done;
    logic [RB-1:0] row;
    logic [CB-1:0] column;
    logic [PB-1:0] pixel;
    logic [7:0] data_out;
    logic ram_write_enable;
    logic ram_access_start;
    logic [RB-1:0] fill_row;
    logic [CB-1:0] fill_column;
    logic [PB-1:0] fill_pixel;
    logic [7:0] fill_data;
    logic fill_write;

    assign done = loader_done | fill_done;

    cmd_dispatch #(
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) u_cmd_dispatch (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .data_valid(data_valid),
        .loader_done(loader_done),
        .fill_done(fill_done),
        .load_enable(load_enable),
        .fill_enable(fill_enable),
        .busy(busy),
        .cmd_error(cmd_error)
    );

    frame_loader #(
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .PIXEL_WIDTH(PIXEL_WIDTH)
    ) u_frame_loader (
        .clk(clk),
        .reset(reset),
        .enable(load_enable),
        .data_in(data_in),
        .row(row),
        .column(column),
        .pixel(pixel),
        .data_out(data_out),
        .ram_write_enable(ram_write_enable),
        .ram_access_start(ram_access_start),
        .done(loader_done)
    );

    frame_fill #(
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .PIXEL_WIDTH(PIXEL_WIDTH)
    ) u_frame_fill (
        .clk(clk),
        .reset(reset),
        .enable(fill_enable),
        .data_in(data_in),
        .fill_row(fill_row),
        .fill_column(fill_column),
        .fill_pixel(fill_pixel),
        .fill_data(fill_data),
        .fill_write(fill_write),
        .done(fill_done)
    );

    frame_buffer #(
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .PIXEL_WIDTH(PIXEL_WIDTH)
    ) u_frame_buffer (
        .clk(clk),
        .reset(reset),
        .row(row),
        .column(column),
        .pixel(pixel),
        .data_in(data_out),
        .ram_write_enable(ram_write_enable),
        .ram_access_start(ram_access_start),
        .fill_row(fill_row),
        .fill_column(fill_column),
        .fill_pixel(fill_pixel),
        .fill_data(fill_data),
        .fill_write(fill_write),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_pixel(rd_pixel),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

/* tests/tb_matrix_cmd.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// matrix command testbench replaying the frame cases with readback checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_matrix_cmd;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W = 4;
    localparam int H = 2;
    localparam int B = 3;
    localparam int FRAME_BYTES = W * H * B;
    localparam int MAX_CASES = 16;
    localparam int MAX_STIM = 512;
    localparam logic [7:0] FILL_OPCODE = 8'h02;

    logic clk = 1'b0;
    logic reset;
    logic [7:0] data_in;
    logic data_valid;
    logic [0:0] rd_row;
    logic [1:0] rd_column;
    logic [1:0] rd_pixel;
    logic [7:0] rd_data;
    logic busy;
    logic done;
    logic cmd_error;

    string case_name [MAX_CASES];
    bit expect_error [MAX_CASES];
    int stim_start [MAX_CASES];
    int stim_len [MAX_CASES];
    int filler_count [MAX_CASES];
    logic [7:0] stim [MAX_STIM];
    logic [7:0] expected [MAX_CASES * FRAME_BYTES];
    int num_cases = 0;

    int cycle_count = 0;
    int cycle_limit = 100;      // raised once the case file is read
    int done_seen;
    int error_seen;
    int busy_seen;
    int case_errors;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    matrix_cmd_top #(
        .BYTES_PER_PIXEL(B),
        .PIXEL_HEIGHT(H),
        .PIXEL_WIDTH(W)
    ) u_matrix_cmd_top (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .data_valid(data_valid),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_pixel(rd_pixel),
        .rd_data(rd_data),
        .busy(busy),
        .done(done),
        .cmd_error(cmd_error)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // flags sampled once per cycle just after the edge
    task automatic next_cycle();
        @(posedge clk);
        #0.5;
        if (done) done_seen++;
        if (cmd_error) error_seen++;
        if (busy) busy_seen++;
    endtask

    task automatic read_token(input int fd, output string tok, output bit ok);
        string rest;
        int n;
        tok = "";
        n = $fscanf(fd, "%s", tok);
        while (n == 1 && tok.getc(0) == 8'h23) begin   // comment up to end of line
            n = $fgets(rest, fd);
            n = $fscanf(fd, "%s", tok);
        end
        ok = (n == 1);
    endtask

    task automatic read_value(input int fd, input bit hex, output int value, inout bit ok);
        string tok;
        bit got;
        int n;
        value = 0;
        n = 0;
        if (ok) begin
            read_token(fd, tok, got);
            if (got && hex) n = $sscanf(tok, "%h", value);
            else if (got) n = $sscanf(tok, "%d", value);
            ok = (n == 1);
        end
    endtask

    task automatic load_cases();
        int fd;
        int c;
        int i;
        int value;
        int stim_fill;
        string tok;
        bit more;
        bit good;
        stim_fill = 0;
        good = 1'b1;
        fd = $fopen("tests/frame_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file tests/frame_cases.txt");
            errors++;
            return;
        end
        read_token(fd, tok, more);
        while (more && good) begin
            c = num_cases;
            good = (c < MAX_CASES);
            if (good) begin
                case_name[c] = tok;
                read_token(fd, tok, good);
                expect_error[c] = (tok == "error");
                good = good && (tok == "error" || tok == "done");
                read_value(fd, 1'b0, value, good);
                stim_len[c] = value;
                read_value(fd, 1'b0, value, good);
                filler_count[c] = value;
                stim_start[c] = stim_fill;
                for (i = 0; i < stim_len[c] && good; i++) begin
                    read_value(fd, 1'b1, value, good);
                    good = good && (stim_fill < MAX_STIM);
                    if (good) stim[stim_fill] = 8'(value);
                    stim_fill++;
                end
                for (i = 0; i < FRAME_BYTES; i++) begin
                    read_value(fd, 1'b1, value, good);
                    expected[c * FRAME_BYTES + i] = 8'(value);
                end
                num_cases++;
                read_token(fd, tok, more);
            end
        end
        $fclose(fd);
        if (!good || num_cases == 0) begin
            $display("case file is malformed or empty near case %0d", num_cases + 1);
            errors++;
        end
    endtask

    // filler bytes go out only while busy is high and are all dropped
    task automatic send_fillers(input int c);
        int i;
        for (i = 0; i < filler_count[c]; i++) begin
            next_cycle();
            if (busy) begin
                data_in = 8'($urandom());
                data_valid = 1'b1;
            end else begin
                $display("case %s: busy was low when filler byte %0d was due", case_name[c], i);
                data_valid = 1'b0;
                case_errors++;
            end
        end
    endtask

    task automatic check_frame(input int c);
        int i;
        logic [7:0] want;
        next_cycle();   // last loaded byte lands a cycle after done
        for (i = 0; i <= FRAME_BYTES; i++) begin
            next_cycle();
            if (i > 0) begin
                want = expected[c * FRAME_BYTES + i - 1];
                if (rd_data !== want) begin
                    $display("MISMATCH rd_data[%0d]: expected 0x%02h, got 0x%02h",
                             i - 1, want, rd_data);
                    case_errors++;
                end
            end
            if (i < FRAME_BYTES) begin
                rd_row = 1'(i / (W * B));
                rd_column = 2'((i / B) % W);
                rd_pixel = 2'(i % B);
            end
        end
    endtask

    task automatic check_count(input string what, input int seen, input int want);
        if (seen != want) begin
            $display("%s was seen in %0d cycles, expected %0d", what, seen, want);
            case_errors++;
        end
    endtask

    task automatic expect_low(input string name, input logic value);
        if (value !== 1'b0) begin
            $display("MISMATCH %s after reset: expected 0x0, got 0x%h", name, value);
            case_errors++;
        end
    endtask

    task automatic run_case(input int c);
        int i;
        bit is_fill;
        case_errors = 0;
        done_seen = 0;
        error_seen = 0;
        busy_seen = 0;
        is_fill = !expect_error[c] && (stim[stim_start[c]] == FILL_OPCODE);
        for (i = 0; i < stim_len[c]; i++) begin
            next_cycle();
            data_in = stim[stim_start[c] + i];
            data_valid = 1'b1;
        end
        send_fillers(c);
        next_cycle();
        data_valid = 1'b0;
        data_in = 8'h00;
        while (done_seen == 0 && error_seen == 0) next_cycle();
        check_frame(c);
        check_count("done", done_seen, expect_error[c] ? 0 : 1);
        check_count("cmd_error", error_seen, expect_error[c] ? 1 : 0);
        check_count("busy", busy_seen, is_fill ? FRAME_BYTES + 1 : 0);   // sweep plus one
        tests_run++;
        if (case_errors == 0) begin
            $display("case %0d %s: ok", c + 1, case_name[c]);
        end else begin
            $display("case %0d %s: %0d errors", c + 1, case_name[c], case_errors);
            tests_failed++;
            errors += case_errors;
        end
    endtask

    initial begin
        reset = 1'b1;
        data_in = 8'h00;
        data_valid = 1'b0;
        rd_row = '0;
        rd_column = '0;
        rd_pixel = '0;
        void'($urandom(32'h7bea_4a81));
        load_cases();
        cycle_limit = 40 * num_cases + 100;
        repeat (4) next_cycle();
        reset = 1'b0;
        next_cycle();
        case_errors = 0;
        expect_low("busy", busy);
        expect_low("done", done);
        expect_low("cmd_error", cmd_error);
        tests_run++;
        $display("reset state: %s", case_errors == 0 ? "ok" : "flags not low");
        tests_failed += (case_errors != 0);
        errors += case_errors;
        for (int c = 0; c < num_cases; c++) begin
            run_case(c);
        end
        $display("tests: %0d run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/frame_cases.txt */
# name  event(done|error)  byte_count  busy_fillers, then byte_count hex bytes to send,
# then 24 expected hex bytes at linear index row*12 + column*3 + pixel
load_order done 25 0
01
a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab
ac ad ae af b0 b1 b2 b3 b4 b5 b6 b7
b7 b6 b5 b4 b3 b2 b1 b0 af ae ad ac
ab aa a9 a8 a7 a6 a5 a4 a3 a2 a1 a0
fill done 4 0
02 11 22 33
33 22 11 33 22 11 33 22 11 33 22 11
33 22 11 33 22 11 33 22 11 33 22 11
busy_drop done 4 6
02 c4 5e 09
09 5e c4 09 5e c4 09 5e c4 09 5e c4
09 5e c4 09 5e c4 09 5e c4 09 5e c4
bad_opcode error 1 0
7f
09 5e c4 09 5e c4 09 5e c4 09 5e c4
09 5e c4 09 5e c4 09 5e c4 09 5e c4
load_after_fill done 25 0
01
40 41 42 43 44 45 46 47 48 49 4a 4b
4c 4d 4e 4f 50 51 52 53 54 55 56 57
57 56 55 54 53 52 51 50 4f 4e 4d 4c
4b 4a 49 48 47 46 45 44 43 42 41 40

/* sim.f */
hw/matrix_pkg.sv
hw/cmd_dispatch.sv
hw/frame_loader.sv
hw/frame_fill.sv
hw/frame_buffer.sv
hw/matrix_cmd_top.sv
tests/tb_matrix_cmd.sv

/* Bender.yml */
package:
  name: matrix_cmd

dependencies: {}

sources:
  - hw/matrix_pkg.sv
  - hw/cmd_dispatch.sv
  - hw/frame_loader.sv
  - hw/frame_fill.sv
  - hw/frame_buffer.sv
  - hw/matrix_cmd_top.sv
  - target: test
    files:
      - tests/tb_matrix_cmd.sv
